// File: board_ctrl.f
board_ctrl_pkg.sv
key_debounce.sv
reset_req_pulser.sv
heartbeat_blinker.sv
board_ctrl_top.sv
tb_board_checker.sv
tb_board_ctrl.sv

// File: Bender.yml
package:
  name: board_ctrl

sources:
  - board_ctrl_pkg.sv
  - key_debounce.sv
  - reset_req_pulser.sv
  - heartbeat_blinker.sv
  - board_ctrl_top.sv
  - target: test
    files:
      - tb_board_checker.sv
      - tb_board_ctrl.sv

// File: tb_board_ctrl.sv
module tb_board_ctrl;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int tb_debounce_timeout = 8;
  localparam int tb_half_period      = 20;
  localparam int stim_cycles         = 3000;
  localparam int drain_cycles        = 40;   // longest pulse plus margin
  localparam int timeout_cycles      = stim_cycles + 500;

  logic                                       fpga_clk_50 = 1'b0;  // low from the start
  logic                                       hps_fpga_reset_n;
  logic [board_ctrl_pkg::key_count-1:0]       key;
  logic [board_ctrl_pkg::switch_count-1:0]    sw;
  logic [2:0]                                 reset_req;
  logic [board_ctrl_pkg::key_count-1:0]       key_debounced;
  logic                                       heartbeat_led;
  logic                                       cold_reset_req_n;
  logic                                       warm_reset_req_n;
  logic                                       debug_reset_req_n;
  logic [board_ctrl_pkg::stm_event_width-1:0] stm_hw_events;

  int     check_count;
  int     key_errors;
  int     led_errors;
  int     pulse_errors;
  int     trace_errors;
  int     total_errors;
  int     cycle_cnt;
  integer seed;
  int     key_run [board_ctrl_pkg::key_count];  // cycles left at current level

  always #20 fpga_clk_50 = ~fpga_clk_50;  // 40 ns period

  board_ctrl_top #(
    .debounce_timeout      (tb_debounce_timeout),
    .heartbeat_half_period (tb_half_period)
  ) DUT (
    .fpga_clk_50       (fpga_clk_50),
    .hps_fpga_reset_n  (hps_fpga_reset_n),
    .key               (key),
    .sw                (sw),
    .reset_req         (reset_req),
    .key_debounced     (key_debounced),
    .heartbeat_led     (heartbeat_led),
    .cold_reset_req_n  (cold_reset_req_n),
    .warm_reset_req_n  (warm_reset_req_n),
    .debug_reset_req_n (debug_reset_req_n),
    .stm_hw_events     (stm_hw_events)
  );

  tb_board_checker #(
    .debounce_timeout (tb_debounce_timeout),
    .half_period      (tb_half_period)
  ) u_checker (
    .fpga_clk_50       (fpga_clk_50),
    .hps_fpga_reset_n  (hps_fpga_reset_n),
    .key               (key),
    .sw                (sw),
    .reset_req         (reset_req),
    .key_debounced     (key_debounced),
    .heartbeat_led     (heartbeat_led),
    .cold_reset_req_n  (cold_reset_req_n),
    .warm_reset_req_n  (warm_reset_req_n),
    .debug_reset_req_n (debug_reset_req_n),
    .stm_hw_events     (stm_hw_events),
    .check_count       (check_count),
    .key_errors        (key_errors),
    .led_errors        (led_errors),
    .pulse_errors      (pulse_errors),
    .trace_errors      (trace_errors)
  );

  // ====================
  // stimulus
  // ====================
  task automatic drive_random_inputs();
    for (int i = 0; i < board_ctrl_pkg::key_count; i++)
    begin
      if (key_run[i] == 0)
      begin
        key[i]     = ~key[i];
        key_run[i] = ($unsigned($random(seed)) % 20) + 1;  // 1 to 20 cycles
      end
      key_run[i] = key_run[i] - 1;
    end
    if (($random(seed) & 7) == 0)
      sw = 4'($random(seed));
    // toggling often enough to hit busy pulsers
    for (int r = 0; r < 3; r++)
    begin
      if (($random(seed) & 7) == 0)
        reset_req[r] = ~reset_req[r];
    end
  endtask

  initial
  begin
    seed             = 3;
    hps_fpga_reset_n = 1'b0;
    key              = '1;  // released
    sw               = '0;
    reset_req        = '0;
    cycle_cnt        = 0;
    for (int i = 0; i < board_ctrl_pkg::key_count; i++)
    begin
      key_run[i] = 0;
    end
    repeat (3) @(posedge fpga_clk_50);
    #2;
    hps_fpga_reset_n = 1'b1;
    repeat (stim_cycles)
    begin
      @(posedge fpga_clk_50);
      #2;
      drive_random_inputs();
    end
    repeat (drain_cycles) @(posedge fpga_clk_50);
    @(negedge fpga_clk_50);
    #1;
    total_errors = key_errors + led_errors + pulse_errors + trace_errors;
    $display("checks %0d, errors %0d (key %0d, led %0d, reset req %0d, trace %0d)",
             check_count, total_errors, key_errors, led_errors, pulse_errors, trace_errors);
    if (total_errors == 0 && check_count > 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  // ====================
  // watchdog
  // ====================
  always @(posedge fpga_clk_50)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles)
    begin
      $display("timeout: run still going after %0d clock cycles", timeout_cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

endmodule

// File: tb_board_checker.sv
module tb_board_checker #(
  parameter int debounce_timeout = 8,
  parameter int half_period      = 20
) (
  input  logic                                       fpga_clk_50,
  input  logic                                       hps_fpga_reset_n,
  input  logic [board_ctrl_pkg::key_count-1:0]       key,
  input  logic [board_ctrl_pkg::switch_count-1:0]    sw,
  input  logic [2:0]                                 reset_req,
  input  logic [board_ctrl_pkg::key_count-1:0]       key_debounced,
  input  logic                                       heartbeat_led,
  input  logic                                       cold_reset_req_n,
  input  logic                                       warm_reset_req_n,
  input  logic                                       debug_reset_req_n,
  input  logic [board_ctrl_pkg::stm_event_width-1:0] stm_hw_events,
  output int                                         check_count,
  output int                                         key_errors,
  output int                                         led_errors,
  output int                                         pulse_errors,
  output int                                         trace_errors
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ew = board_ctrl_pkg::stm_event_width;

  // ====================
  // model state
  // ====================
  logic [board_ctrl_pkg::key_count-1:0] key_model;   // expected clean keys
  int          unequal_run [board_ctrl_pkg::key_count];  // unequal samples in a row
  int          edge_cnt;        // edges since reset release
  int          low_left [3];    // cycles of pulse still to come
  logic        prev1 [3];       // request sampled one edge ago
  logic        prev2 [3];       // two edges ago
  int          pulse_len [3];
  string       pulse_name [3];
  wire  [2:0]  pulse_out_n;
  logic        rise;
  logic [ew-1:0] trace_exp;

  // outputs gathered by request index
  assign pulse_out_n[board_ctrl_pkg::cold]  = cold_reset_req_n;
  assign pulse_out_n[board_ctrl_pkg::warm]  = warm_reset_req_n;
  assign pulse_out_n[board_ctrl_pkg::debug] = debug_reset_req_n;

  task automatic reset_models();
    key_model = '1;  // keys released
    edge_cnt  = 0;
    for (int i = 0; i < board_ctrl_pkg::key_count; i++)
    begin
      unequal_run[i] = 0;
    end
    for (int r = 0; r < 3; r++)
    begin
      low_left[r] = 0;
      prev1[r]    = 1'b0;
      prev2[r]    = 1'b0;
    end
  endtask

  // prints a mismatch, returns 1 when the values agree
  function automatic bit check_value(input string name, input logic [ew-1:0] expected,
                                     input logic [ew-1:0] actual);
    if (expected !== actual)
    begin
      $display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  initial
  begin
    pulse_len[board_ctrl_pkg::cold]   = board_ctrl_pkg::cold_pulse_cycles;
    pulse_len[board_ctrl_pkg::warm]   = board_ctrl_pkg::warm_pulse_cycles;
    pulse_len[board_ctrl_pkg::debug]  = board_ctrl_pkg::debug_pulse_cycles;
    pulse_name[board_ctrl_pkg::cold]  = "cold_reset_req_n";
    pulse_name[board_ctrl_pkg::warm]  = "warm_reset_req_n";
    pulse_name[board_ctrl_pkg::debug] = "debug_reset_req_n";
    check_count  = 0;
    key_errors   = 0;
    led_errors   = 0;
    pulse_errors = 0;
    trace_errors = 0;
    reset_models();
  end

  // ====================
  // cycle models
  // ====================
  // inputs move 2 ns after the edge, so they are settled here
  always @(posedge fpga_clk_50)
  begin
    if (!hps_fpga_reset_n)
    begin
      reset_models();
    end
    else
    begin
      edge_cnt = edge_cnt + 1;
      for (int i = 0; i < board_ctrl_pkg::key_count; i++)
      begin
        if (key[i] != key_model[i])
        begin
          unequal_run[i] = unequal_run[i] + 1;
          if (unequal_run[i] == debounce_timeout)
          begin
            key_model[i]   = key[i];  // held long enough
            unequal_run[i] = 0;
          end
        end
        else
        begin
          unequal_run[i] = 0;  // glitch ended
        end
      end
      for (int r = 0; r < 3; r++)
      begin
        rise = prev1[r] && !prev2[r];
        if (low_left[r] > 0)
        begin
          low_left[r] = low_left[r] - 1;  // busy, rise dropped
        end
        else if (rise)
        begin
          low_left[r] = pulse_len[r];
        end
        prev2[r] = prev1[r];
        prev1[r] = reset_req[r];
      end
    end
  end

  // ====================
  // comparison
  // ====================
  always @(negedge fpga_clk_50)
  begin
    check_count = check_count + 1;
    if (!check_value("key_debounced", ew'(key_model), ew'(key_debounced)))
      key_errors = key_errors + 1;
    if (!check_value("heartbeat_led", ew'(((edge_cnt / half_period) % 2) == 1),
                     ew'(heartbeat_led)))
      led_errors = led_errors + 1;
    for (int r = 0; r < 3; r++)
    begin
      if (!check_value(pulse_name[r], ew'(low_left[r] == 0), ew'(pulse_out_n[r])))
        pulse_errors = pulse_errors + 1;
    end
    trace_exp = {15'b0, sw, 7'b0, key_model};  // keys, led gap, switches, spare
    if (!check_value("stm_hw_events", trace_exp, stm_hw_events))
      trace_errors = trace_errors + 1;
  end

endmodule

// File: board_ctrl_top.sv
module board_ctrl_top #(
  parameter int debounce_timeout      = board_ctrl_pkg::debounce_timeout_default,
  parameter int heartbeat_half_period = board_ctrl_pkg::heartbeat_half_period_default
) (
  input  logic                                       fpga_clk_50,
  input  logic                                       hps_fpga_reset_n,

  // board inputs
  input  logic [board_ctrl_pkg::key_count-1:0]       key,        // active low
  input  logic [board_ctrl_pkg::switch_count-1:0]    sw,
  input  logic [2:0]                                 reset_req,  // by reset_req_e

  // cleaned keys and led
  output logic [board_ctrl_pkg::key_count-1:0]       key_debounced,
  output logic                                       heartbeat_led,

  // reset requests towards the hps, active low
  output logic                                       cold_reset_req_n,
  output logic                                       warm_reset_req_n,
  output logic                                       debug_reset_req_n,

  // trace events
  output logic [board_ctrl_pkg::stm_event_width-1:0] stm_hw_events
);

  // ====================
  // key cleanup
  // ====================
  key_debounce #(
    .width   (board_ctrl_pkg::key_count),
    .timeout (debounce_timeout)
  ) u_key_debounce (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key_raw          (key),
    .key_clean        (key_debounced)
  );

  // ====================
  // reset request pulses
  // ====================
  reset_req_pulser #(
    .pulse_cycles (board_ctrl_pkg::cold_pulse_cycles)
  ) u_cold_pulser (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[board_ctrl_pkg::cold]),
    .reset_req_n      (cold_reset_req_n)
  );

  // short one, 2 cycles
  reset_req_pulser #(
    .pulse_cycles (board_ctrl_pkg::warm_pulse_cycles)
  ) u_warm_pulser (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[board_ctrl_pkg::warm]),
    .reset_req_n      (warm_reset_req_n)
  );

  // longest pulse, sets pulse_count_width
  reset_req_pulser #(
    .pulse_cycles (board_ctrl_pkg::debug_pulse_cycles)
  ) u_debug_pulser (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[board_ctrl_pkg::debug]),
    .reset_req_n      (debug_reset_req_n)
  );

  // ====================
  // heartbeat
  // ====================
  heartbeat_blinker #(
    .half_period (heartbeat_half_period)
  ) u_heartbeat_blinker (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .led              (heartbeat_led)
  );

  // trace word, lsb first
  //   [1:0]   debounced keys
  //   [8:2]   old led port slot, tied low
  //   [12:9]  switches
  //   [27:13] spare
  assign stm_hw_events = {
    {15{1'b0}},
    sw,
    {7{1'b0}},
    key_debounced
  };

endmodule

// File: heartbeat_blinker.sv
module heartbeat_blinker #(
  parameter int half_period = board_ctrl_pkg::heartbeat_half_period_default
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic led
);

  localparam int cw = board_ctrl_pkg::heartbeat_count_width;

  // wrap point of the free running counter
  localparam logic [cw-1:0] terminal = cw'(half_period - 1);

  logic [cw-1:0] tick_cnt;

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      tick_cnt <= '0;
      led      <= 1'b0;  // dark out of reset
    end
    else if (tick_cnt == terminal)
    begin
      tick_cnt <= '0;
      led      <= ~led;  // one half period done
    end
    else
    begin
      tick_cnt <= tick_cnt + cw'(1);
    end
  end

  // counter stays inside its period
  cnt_in_range: assert property (
    @(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    tick_cnt <= terminal
  );

endmodule

// File: reset_req_pulser.sv
module reset_req_pulser #(
  parameter int pulse_cycles = board_ctrl_pkg::cold_pulse_cycles
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic req,          // raw request, active high
  output logic reset_req_n   // stretched pulse, active low
);

  localparam int cw = board_ctrl_pkg::pulse_count_width;

  // counter runs from pulse_cycles - 1 down to zero
  localparam logic [cw-1:0] load_value = cw'(pulse_cycles - 1);

  logic                        req_q;     // input register
  logic                        req_prev;  // previous sample of req_q
  logic                        req_rise;
  board_ctrl_pkg::pulse_state_e state;
  logic [cw-1:0]               remain;

  // ====================
  // input sampling
  // ====================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_q    <= 1'b0;
      req_prev <= 1'b0;
    end
    else
    begin
      req_q    <= req;
      req_prev <= req_q;
    end
  end

  assign req_rise = req_q & ~req_prev;  // 0 -> 1 between samples

  // ====================
  // pulse fsm
  // ====================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      state  <= board_ctrl_pkg::pulse_idle;
      remain <= '0;
    end
    else
    begin
      unique case (state)
        board_ctrl_pkg::pulse_idle:
        begin
          if (req_rise)
          begin
            state  <= board_ctrl_pkg::pulse_active;
            remain <= load_value;
          end
        end
        board_ctrl_pkg::pulse_active:
        begin
          // edges here are dropped, nothing queued
          if (remain == '0)
          begin
            state <= board_ctrl_pkg::pulse_idle;
          end
          else
          begin
            remain <= remain - cw'(1);
          end
        end
      endcase
    end
  end

  assign reset_req_n = (state != board_ctrl_pkg::pulse_active);  // low while active

  // ====================
  // checks
  // ====================
  // busy requests must not stretch the pulse
  pulse_max_length: assert property (
    @(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    (!reset_req_n) [*pulse_cycles] |=> reset_req_n
  );

endmodule

// File: key_debounce.sv
module key_debounce #(
  parameter int width   = board_ctrl_pkg::key_count,
  parameter int timeout = board_ctrl_pkg::debounce_timeout_default
) (
  input  logic             fpga_clk_50,
  input  logic             hps_fpga_reset_n,
  input  logic [width-1:0] key_raw,    // straight from the pins
  output logic [width-1:0] key_clean   // settled level, still active low
);

  localparam int cw = board_ctrl_pkg::debounce_count_width;

  // last count before the flip
  localparam logic [cw-1:0] terminal = cw'(timeout - 1);

  // one stability counter per key
  logic [cw-1:0] stable_cnt [width];

  // ====================
  // stability counters
  // ====================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_clean <= '1;  // released
      for (int i = 0; i < width; i++)
      begin
        stable_cnt[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < width; i++)
      begin
        if (key_raw[i] == key_clean[i])
        begin
          stable_cnt[i] <= '0;  // glitch over, start again
        end
        else if (stable_cnt[i] == terminal)
        begin
          // timeout unequal samples in a row, accept the new level
          key_clean[i]  <= key_raw[i];
          stable_cnt[i] <= '0;
        end
        else
        begin
          stable_cnt[i] <= stable_cnt[i] + cw'(1);
        end
      end
    end
  end

  // ====================
  // checks
  // ====================
  for (genvar g = 0; g < width; g++)
  begin : g_key_chk
    // a clean key only moves right after its counter ran out
    key_flip_after_timeout: assert property (
      @(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
      $changed(key_clean[g]) |-> ($past(stable_cnt[g]) == terminal)
    );
  end

endmodule

// File: board_ctrl_pkg.sv
package board_ctrl_pkg;

  // ====================
  // board widths
  // ====================
  localparam int key_count       = 2;   // push keys, active low
  localparam int switch_count    = 4;   // slide switches
  localparam int stm_event_width = 28;  // trace event word into the hps

  // ====================
  // timing defaults
  // ====================
  // debounce window, 1 ms at 50 MHz
  localparam int debounce_timeout_default = 50000;
  localparam int debounce_count_width     = 16;  // holds timeout - 1

  // led toggles twice a second at 50 MHz
  localparam int heartbeat_half_period_default = 25000000;
  localparam int heartbeat_count_width         = 26;

  // reset request pulse lengths, in fpga_clk_50 cycles
  localparam int cold_pulse_cycles  = 6;
  localparam int warm_pulse_cycles  = 2;
  localparam int debug_pulse_cycles = 32;
  localparam int pulse_count_width  = 6;   // covers debug - 1

  // ====================
  // enums
  // ====================
  // bit positions inside the reset_req vector
  typedef enum logic [1:0] {
    cold  = 2'd0,
    warm  = 2'd1,
    debug = 2'd2
  } reset_req_e;

  // pulser fsm
  typedef enum logic {
    pulse_idle   = 1'b0,  // output high, watching for an edge
    pulse_active = 1'b1   // output low, counting down
  } pulse_state_e;

endpackage
